// ==== build.f ====
dcache_pkg.sv
cache_way_ram.sv
line_store_merge.sv
dcache_lookup.sv
dcache_resolve.sv
dcache_top.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_dcache.sv

// ==== cache_way_ram.sv ====
`timescale 1ns/10ps

module cache_way_ram import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  index_t     rd_index_i,
    input  way_write_t wr_i,
    output tag_entry_t tag_o,
    output line_t      line_o
);

    tag_t                tag_mem [NUM_SETS];
    line_t               line_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    line_t               rd_line;
    logic                same_index;

    assign same_index = wr_i.index == rd_index_i;

    always_ff @(posedge clk) begin
        if (wr_i.tag_we) begin
            tag_mem[wr_i.index] <= wr_i.tag_entry.tag;
        end
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (wr_i.byte_we[b]) begin
                line_mem[wr_i.index][b*8 +: 8] <= wr_i.line[b*8 +: 8];
            end
        end
    end

    // status bits live in flops so that reset can clear every set
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_i.tag_we) begin
            valid_q[wr_i.index] <= wr_i.tag_entry.valid;
            dirty_q[wr_i.index] <= wr_i.tag_entry.dirty;
        end
    end

    // write-first read, a same-cycle write to the read set is returned
    always_comb begin
        rd_line = line_mem[rd_index_i];
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (same_index && wr_i.byte_we[b]) begin
                rd_line[b*8 +: 8] = wr_i.line[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        line_o <= rd_line;
        if (rst) begin
            tag_o <= '0;
        end else if (same_index && wr_i.tag_we) begin
            tag_o <= wr_i.tag_entry;
        end else begin
            tag_o <= '{dirty: dirty_q[rd_index_i], valid: valid_q[rd_index_i],
                       tag: tag_mem[rd_index_i]};
        end
    end

endmodule

// ==== dcache_lookup.sv ====
`timescale 1ns/10ps

module dcache_lookup import dcache_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid_i,
    input  cpu_req_t                  req_i,
    input  logic                      stall_i,
    input  way_write_t [NUM_WAYS-1:0] way_wr_i,
    input  tag_entry_t [NUM_WAYS-1:0] tag_i,
    input  line_t      [NUM_WAYS-1:0] line_i,
    output index_t                    rd_index_o,
    output lookup_t                   lookup_o
);

    logic                      s2_valid;
    cpu_req_t                  s2_req;
    index_t                    s2_index;
    tag_t                      s2_tag;
    tag_entry_t [NUM_WAYS-1:0] fwd_tag;
    line_t      [NUM_WAYS-1:0] fwd_line;
    logic       [NUM_WAYS-1:0] way_hit;
    lookup_t                   lookup_d;

    assign s2_index = addr_index(s2_req.addr);
    assign s2_tag   = addr_tag(s2_req.addr);

    // while stalled the held set is read again so the RAM outputs stay current
    assign rd_index_o = stall_i ? s2_index : addr_index(req_i.addr);

    // stage 1 register
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (!stall_i) begin
            s2_valid <= valid_i;
            s2_req   <= req_i;
        end
    end

    // stage 2: pick up writes landing on this set, then compare tags
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            fwd_tag[w]  = tag_i[w];
            fwd_line[w] = line_i[w];
            if (way_wr_i[w].index == s2_index) begin
                if (way_wr_i[w].tag_we) begin
                    fwd_tag[w] = way_wr_i[w].tag_entry;
                end
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (way_wr_i[w].byte_we[b]) begin
                        fwd_line[w][b*8 +: 8] = way_wr_i[w].line[b*8 +: 8];
                    end
                end
            end
            way_hit[w] = fwd_tag[w].valid && (fwd_tag[w].tag == s2_tag);
        end
    end

    always_comb begin
        lookup_d.valid   = s2_valid;
        lookup_d.req     = s2_req;
        lookup_d.hit     = |way_hit;
        lookup_d.hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                lookup_d.hit_way = way_sel_t'(w);
            end
        end
        lookup_d.tag  = fwd_tag;
        lookup_d.line = fwd_line;
    end

    // stage 2 register
    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_o.valid <= 1'b0;
        end else if (!stall_i) begin
            lookup_o <= lookup_d;
        end
    end

endmodule

// ==== dcache_pkg.sv ====
package dcache_pkg;

    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 256;
    localparam int LINE_BYTES = 16;
    localparam int WORD_BYTES = 4;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 8;
    localparam int TAG_W      = 20;
    localparam int WORD_SEL_W = 2;

    typedef logic [31:0]               addr_t;
    typedef logic [WORD_BYTES*8-1:0]   word_t;
    // all zeros marks a load
    typedef logic [WORD_BYTES-1:0]     wstrb_t;
    typedef logic [LINE_BYTES*8-1:0]   line_t;
    typedef logic [LINE_BYTES-1:0]     line_strb_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [WORD_SEL_W-1:0]     word_sel_t;
    typedef logic [0:0]                way_sel_t;

    typedef struct packed {
        logic dirty;
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        addr_t  addr;
        wstrb_t wstrb;
        word_t  wdata;
    } cpu_req_t;

    // registered result of the tag compare, handed to stage 3
    typedef struct packed {
        logic                           valid;
        cpu_req_t                       req;
        logic                           hit;
        way_sel_t                       hit_way;
        tag_entry_t [NUM_WAYS-1:0]      tag;
        line_t      [NUM_WAYS-1:0]      line;
    } lookup_t;

    // one write command to one way
    typedef struct packed {
        logic       tag_we;
        index_t     index;
        tag_entry_t tag_entry;
        line_strb_t byte_we;
        line_t      line;
    } way_write_t;

    typedef enum logic [2:0] {
        IDLE,
        WB_REQ,
        WB_WAIT,
        REFILL_REQ,
        REFILL_WAIT
    } resolve_state_e;

    function automatic index_t addr_index(addr_t a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(addr_t a);
        return a[OFFSET_W + INDEX_W +: TAG_W];
    endfunction

    function automatic word_sel_t addr_word(addr_t a);
        return a[OFFSET_W - 1 -: WORD_SEL_W];
    endfunction

    function automatic addr_t line_addr(tag_t t, index_t i);
        return {t, i, {OFFSET_W{1'b0}}};
    endfunction

endpackage

// ==== dcache_resolve.sv ====
`timescale 1ns/10ps

module dcache_resolve import dcache_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  lookup_t                   lookup_i,
    output logic                      stall_o,
    output logic                      data_ok_o,
    output word_t                     rdata_o,
    output way_write_t [NUM_WAYS-1:0] way_wr_o,
    output logic                      mem_req_o,
    output logic                      mem_we_o,
    output addr_t                     mem_addr_o,
    output line_t                     mem_wdata_o,
    input  logic                      mem_ready_i,
    input  logic                      mem_rvalid_i,
    input  logic                      mem_bvalid_i,
    input  line_t                     mem_rdata_i
);

    resolve_state_e state_q;
    resolve_state_e state_d;
    logic [15:0]    lfsr_q;
    way_sel_t       victim_q;
    way_sel_t       victim;
    logic           is_store;
    logic           miss;
    logic           victim_dirty;
    index_t         req_index;
    tag_t           req_tag;
    word_sel_t      req_word;
    line_t          src_line;
    line_t          merged_line;
    line_strb_t     merged_we;

    assign is_store  = |lookup_i.req.wstrb;
    assign req_index = addr_index(lookup_i.req.addr);
    assign req_tag   = addr_tag(lookup_i.req.addr);
    assign req_word  = addr_word(lookup_i.req.addr);
    assign miss      = (state_q == IDLE) && lookup_i.valid && !lookup_i.hit;

    // victim comes straight from the LFSR until the miss latches it
    assign victim       = (state_q == IDLE) ? lfsr_q[0] : victim_q;
    assign victim_dirty = lookup_i.tag[victim].valid && lookup_i.tag[victim].dirty;

    assign stall_o = miss || (state_d != IDLE);

    // x^16 + x^14 + x^13 + x^11 + 1, free running
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= 16'h0001;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            victim_q <= lfsr_q[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (miss) begin
                    state_d = victim_dirty ? WB_REQ : REFILL_REQ;
                end
            end
            WB_REQ: begin
                if (mem_ready_i) begin
                    state_d = WB_WAIT;
                end
            end
            WB_WAIT: begin
                if (mem_bvalid_i) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (mem_ready_i) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // write-back goes out first and blocks the refill read
    always_comb begin
        mem_req_o   = 1'b0;
        mem_we_o    = 1'b0;
        mem_addr_o  = line_addr(req_tag, req_index);
        mem_wdata_o = lookup_i.line[victim];
        if (state_q == WB_REQ || state_q == WB_WAIT) begin
            mem_addr_o = line_addr(lookup_i.tag[victim].tag, req_index);
        end
        if ((state_q == WB_REQ || state_q == REFILL_REQ) && mem_ready_i) begin
            mem_req_o = 1'b1;
            mem_we_o  = state_q == WB_REQ;
        end
    end

    // hit line when idle, refill data otherwise
    assign src_line = (state_q == IDLE) ? lookup_i.line[lookup_i.hit_way] : mem_rdata_i;
    assign rdata_o  = src_line[req_word * (WORD_BYTES * 8) +: (WORD_BYTES * 8)];

    line_store_merge u_merge (
        .line_i     (src_line),
        .word_sel_i (req_word),
        .wstrb_i    (lookup_i.req.wstrb),
        .wdata_i    (lookup_i.req.wdata),
        .line_o     (merged_line),
        .byte_we_o  (merged_we)
    );

    always_comb begin
        data_ok_o = 1'b0;
        way_wr_o  = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_wr_o[w].index = req_index;
        end
        if ((state_q == IDLE) && lookup_i.valid && lookup_i.hit) begin
            data_ok_o = 1'b1;
            if (is_store) begin
                way_wr_o[lookup_i.hit_way].tag_we    = 1'b1;
                way_wr_o[lookup_i.hit_way].tag_entry = '{dirty: 1'b1, valid: 1'b1, tag: req_tag};
                way_wr_o[lookup_i.hit_way].byte_we   = merged_we;
                way_wr_o[lookup_i.hit_way].line      = merged_line;
            end
        end else if ((state_q == REFILL_WAIT) && mem_rvalid_i) begin
            data_ok_o = 1'b1;
            // whole line replaced, dirty only when a store was merged in
            way_wr_o[victim_q].tag_we    = 1'b1;
            way_wr_o[victim_q].tag_entry = '{dirty: is_store, valid: 1'b1, tag: req_tag};
            way_wr_o[victim_q].byte_we   = '1;
            way_wr_o[victim_q].line      = merged_line;
        end
    end

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_i,
    input  cpu_req_t req_i,
    output logic     ready_o,
    output logic     data_ok_o,
    output word_t    rdata_o,
    output logic     mem_req_o,
    output logic     mem_we_o,
    output addr_t    mem_addr_o,
    output line_t    mem_wdata_o,
    input  logic     mem_ready_i,
    input  logic     mem_rvalid_i,
    input  logic     mem_bvalid_i,
    input  line_t    mem_rdata_i
);

    logic                      stall;
    index_t                    rd_index;
    lookup_t                   lookup;
    way_write_t [NUM_WAYS-1:0] way_wr;
    tag_entry_t [NUM_WAYS-1:0] way_tag;
    line_t      [NUM_WAYS-1:0] way_line;

    assign ready_o = ~stall;

    dcache_lookup u_lookup (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (valid_i),
        .req_i      (req_i),
        .stall_i    (stall),
        .way_wr_i   (way_wr),
        .tag_i      (way_tag),
        .line_i     (way_line),
        .rd_index_o (rd_index),
        .lookup_o   (lookup)
    );

    dcache_resolve u_resolve (
        .clk          (clk),
        .rst          (rst),
        .lookup_i     (lookup),
        .stall_o      (stall),
        .data_ok_o    (data_ok_o),
        .rdata_o      (rdata_o),
        .way_wr_o     (way_wr),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ready_i  (mem_ready_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_bvalid_i (mem_bvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    cache_way_ram u_way0 (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (rd_index),
        .wr_i       (way_wr[0]),
        .tag_o      (way_tag[0]),
        .line_o     (way_line[0])
    );

    cache_way_ram u_way1 (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (rd_index),
        .wr_i       (way_wr[1]),
        .tag_o      (way_tag[1]),
        .line_o     (way_line[1])
    );

endmodule

// ==== line_store_merge.sv ====
`timescale 1ns/10ps

module line_store_merge import dcache_pkg::*; (
    input  line_t      line_i,
    input  word_sel_t  word_sel_i,
    input  wstrb_t     wstrb_i,
    input  word_t      wdata_i,
    output line_t      line_o,
    output line_strb_t byte_we_o
);

    int pos;

    // overlay strobed bytes on the addressed word, everything else passes
    always_comb begin
        pos       = 0;
        line_o    = line_i;
        byte_we_o = '0;
        for (int b = 0; b < WORD_BYTES; b++) begin
            pos = int'(word_sel_i) * WORD_BYTES + b;
            if (wstrb_i[b]) begin
                line_o[pos*8 +: 8] = wdata_i[b*8 +: 8];
                byte_we_o[pos]     = 1'b1;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_dcache -f build.f -o sim_dcache \
    && ./obj_dir/sim_dcache > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

    // reset held for two rising edges, released just after the second
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/10ps

module tb_dcache import dcache_pkg::*; ();

    localparam word_t FILL_KEY = 32'h5ca1_ab1e;
    // final sweep of the random test touches at most 4 sets x 12 tags x 4 words
    localparam int MAX_REQUESTS    = 2 + 6 + 4 + 6 + 300 + 4 * 12 * 4;
    localparam int WATCHDOG_CYCLES = 200 * MAX_REQUESTS;

    logic     clk;
    logic     rst;
    logic     valid;
    cpu_req_t req;
    logic     ready;
    logic     data_ok;
    word_t    rdata;
    logic     mem_req;
    logic     mem_we;
    addr_t    mem_addr;
    line_t    mem_wdata;
    logic     mem_ready;
    logic     mem_rvalid;
    logic     mem_bvalid;
    line_t    mem_rdata;

    word_t    ref_mem [addr_t];
    bit       touched [addr_t];
    cpu_req_t pend_req [$];
    int       pend_edge [$];
    int       done_edges [$];
    int       cycles;
    int       last_latency = 0;
    int       wb_count = 0;
    string    test_name;

    tb_clock_gen u_clk (
        .clk_o (clk),
        .rst_o (rst)
    );

    tb_mem_model #(.FILL_KEY(FILL_KEY)) u_mem (
        .clk          (clk),
        .rst          (rst),
        .mem_req_i    (mem_req),
        .mem_we_i     (mem_we),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .mem_ready_o  (mem_ready),
        .mem_rvalid_o (mem_rvalid),
        .mem_bvalid_o (mem_bvalid),
        .mem_rdata_o  (mem_rdata)
    );

    dcache_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid),
        .req_i        (req),
        .ready_o      (ready),
        .data_ok_o    (data_ok),
        .rdata_o      (rdata),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_ready_i  (mem_ready),
        .mem_rvalid_i (mem_rvalid),
        .mem_bvalid_i (mem_bvalid),
        .mem_rdata_i  (mem_rdata)
    );

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_word(input string test, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", test, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_mem_line(input string test, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", test, exp, act);
            stop_on_failure();
        end
    endtask

    // reference memory starts as address ^ key and follows completed stores
    function automatic word_t ref_word(addr_t a);
        addr_t w_addr;
        w_addr = {a[31:2], 2'b00};
        if (ref_mem.exists(w_addr)) begin
            return ref_mem[w_addr];
        end
        return w_addr ^ FILL_KEY;
    endfunction

    function automatic line_t ref_line(addr_t a);
        line_t l;
        for (int w = 0; w < LINE_BYTES / WORD_BYTES; w++) begin
            l[w*32 +: 32] = ref_word(a + addr_t'(w * WORD_BYTES));
        end
        return l;
    endfunction

    function automatic void apply_store(cpu_req_t r);
        addr_t a;
        word_t w;
        a = {r.addr[31:2], 2'b00};
        w = ref_word(a);
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (r.wstrb[b]) begin
                w[b*8 +: 8] = r.wdata[b*8 +: 8];
            end
        end
        ref_mem[a] = w;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    // responses come back in request order; outputs sampled mid-cycle
    always @(negedge clk) begin
        cpu_req_t done;
        if (!rst && data_ok) begin
            if (pend_req.size() == 0) begin
                $display("data_ok pulsed while no request was outstanding");
                stop_on_failure();
            end else begin
                done = pend_req.pop_front();
                last_latency = cycles + 1 - pend_edge.pop_front();
                done_edges.push_back(cycles + 1);
                if (done.wstrb == '0) begin
                    check_word(test_name, ref_word(done.addr), rdata);
                end else begin
                    apply_store(done);
                end
            end
        end
        if (!rst && mem_req && mem_we) begin
            wb_count++;
            check_mem_line(test_name, ref_line(mem_addr), mem_wdata);
        end
    end

    // entered just after a rising edge, returns just after the accepting edge
    task automatic send(input addr_t a, input wstrb_t s, input word_t d);
        valid = 1'b1;
        req   = '{addr: a, wstrb: s, wdata: d};
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        pend_req.push_back(req);
        pend_edge.push_back(cycles + 1);
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pend_req.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_read_miss_hit();
        addr_t base;
        int    miss_latency;
        base      = 32'h0001_2340;
        test_name = "test_read_miss_hit";
        send(base, 4'b0000, '0);
        wait_drain();
        miss_latency = last_latency;
        if (miss_latency <= 2) begin
            $display("%s: load to a cold line came back as fast as a hit", test_name);
            stop_on_failure();
        end
        send(base + 4, 4'b0000, '0);
        wait_drain();
        if (last_latency != 2) begin
            $display("%s: load hit answered %0d cycles after acceptance instead of 2",
                     test_name, last_latency);
            stop_on_failure();
        end
    endtask

    task automatic test_store_bytes();
        addr_t base;
        base      = 32'h0001_2340;
        test_name = "test_store_bytes";
        send(base + 8, 4'b0010, 32'hdead_beef);
        send(base + 8, 4'b0000, '0);
        send(base + 8, 4'b1100, 32'h1234_5678);
        send(base + 8, 4'b0000, '0);
        send(base + 12, 4'b1111, 32'hcafe_f00d);
        send(base + 12, 4'b0000, '0);
        wait_drain();
    endtask

    task automatic test_back_to_back();
        addr_t base;
        int    first;
        base      = 32'h0001_2340;
        test_name = "test_back_to_back";
        first     = done_edges.size();
        for (int i = 0; i < 4; i++) begin
            send(base + addr_t'(i * 4), 4'b0000, '0);
        end
        wait_drain();
        for (int i = 1; i < 4; i++) begin
            if (done_edges[first + i] != done_edges[first + i - 1] + 1) begin
                $display("%s: response %0d did not follow the previous one a cycle later",
                         test_name, i);
                stop_on_failure();
            end
        end
    endtask

    task automatic test_eviction_writeback();
        addr_t a;
        int    wb_before;
        test_name = "test_eviction_writeback";
        wb_before = wb_count;
        // three tags on set 0x37, word i of line i
        for (int i = 0; i < 3; i++) begin
            a = 32'h00a1_0370 + addr_t'(i) * 32'h0000_1000 + addr_t'(i * 4);
            send(a, 4'b1111, 32'h4400_0000 + word_t'(i));
        end
        for (int i = 0; i < 3; i++) begin
            a = 32'h00a1_0370 + addr_t'(i) * 32'h0000_1000 + addr_t'(i * 4);
            send(a, 4'b0000, '0);
        end
        wait_drain();
        if (wb_count == wb_before) begin
            $display("%s: three dirty lines in one set produced no write-back", test_name);
            stop_on_failure();
        end
    endtask

    task automatic test_random_mix();
        addr_t  a;
        wstrb_t s;
        test_name = "test_random_mix";
        touched.delete();
        for (int i = 0; i < 300; i++) begin
            a = {20'h00b00 + 20'($urandom_range(11, 0)), 8'h50 + 8'($urandom_range(3, 0)),
                 2'($urandom_range(3, 0)), 2'b00};
            if ($urandom_range(1, 0) == 1) begin
                s = wstrb_t'($urandom_range(15, 1));
            end else begin
                s = '0;
            end
            send(a, s, $urandom());
            touched[a] = 1'b1;
        end
        foreach (touched[k]) begin
            send(k, 4'b0000, '0);
        end
        wait_drain();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_on_failure();
    end

    initial begin
        void'($urandom(84));
        valid     = 1'b0;
        req       = '0;
        test_name = "reset";
        @(negedge rst);
        @(posedge clk);
        #1;
        test_read_miss_hit();
        test_store_bytes();
        test_back_to_back();
        test_eviction_writeback();
        test_random_mix();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/10ps

module tb_mem_model import dcache_pkg::*; #(
    parameter word_t FILL_KEY = '0
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  mem_req_i,
    input  logic  mem_we_i,
    input  addr_t mem_addr_i,
    input  line_t mem_wdata_i,
    output logic  mem_ready_o,
    output logic  mem_rvalid_o,
    output logic  mem_bvalid_o,
    output line_t mem_rdata_o
);

    line_t       lines [addr_t];
    int unsigned wait_cycles;

    // lines never written read back as address ^ key, word by word
    function automatic line_t read_line(addr_t a);
        line_t l;
        if (lines.exists(a)) begin
            return lines[a];
        end
        for (int w = 0; w < LINE_BYTES / WORD_BYTES; w++) begin
            l[w*32 +: 32] = (a + addr_t'(w * WORD_BYTES)) ^ FILL_KEY;
        end
        return l;
    endfunction

    initial begin
        mem_ready_o  = 1'b0;
        mem_rvalid_o = 1'b0;
        mem_bvalid_o = 1'b0;
        mem_rdata_o  = '0;
        wait_cycles  = 0;
        forever begin
            @(posedge clk);
            mem_rvalid_o <= 1'b0;
            mem_bvalid_o <= 1'b0;
            if (rst) begin
                mem_ready_o <= 1'b0;
                wait_cycles = $urandom_range(3, 0);
            end else if (mem_req_i && mem_ready_o) begin
                // answer in the next cycle, then go busy for a random while
                mem_ready_o <= 1'b0;
                if (mem_we_i) begin
                    lines[mem_addr_i] = mem_wdata_i;
                    mem_bvalid_o <= 1'b1;
                end else begin
                    mem_rdata_o  <= read_line(mem_addr_i);
                    mem_rvalid_o <= 1'b1;
                end
                wait_cycles = $urandom_range(3, 0);
            end else if (!mem_ready_o) begin
                if (wait_cycles == 0) begin
                    mem_ready_o <= 1'b1;
                end else begin
                    wait_cycles--;
                end
            end
        end
    end

endmodule
